// File: source/trigger_delay_pkg.sv
package trigger_delay_pkg;

    // =========================================================================
    // Types
    // =========================================================================
    typedef logic [7:0]  byte_t;
    typedef logic [31:0] cycles_t;      // Delay, width or edge count in clock cycles
    typedef logic [15:0] trig_count_t;  // Accepted triggers, wraps around
    typedef logic [1:0]  edge_sel_t;

    localparam edge_sel_t EDGE_RISING  = 2'd0;
    localparam edge_sel_t EDGE_FALLING = 2'd1;
    localparam edge_sel_t EDGE_BOTH    = 2'd2;  // 3 also means both

    localparam logic TRIGGER_MODE_EXTERNAL = 1'b0;
    localparam logic TRIGGER_MODE_INTERNAL = 1'b1;
    localparam logic ARMED_MODE_SINGLE     = 1'b0;
    localparam logic ARMED_MODE_REPEAT     = 1'b1;
    localparam logic COUNTER_MODE_DISABLED = 1'b0;
    localparam logic COUNTER_MODE_ENABLED  = 1'b1;

    // =========================================================================
    // Command codes
    // =========================================================================
    localparam byte_t CMD_SET_DELAY        = 8'h01;  // 4 byte payload
    localparam byte_t CMD_SET_WIDTH        = 8'h02;  // 4 byte payload
    localparam byte_t CMD_SET_EDGE         = 8'h03;
    localparam byte_t CMD_SET_TRIGGER_MODE = 8'h04;
    localparam byte_t CMD_SET_COUNTER_MODE = 8'h05;
    localparam byte_t CMD_SET_EDGE_TARGET  = 8'h06;  // 4 byte payload
    localparam byte_t CMD_ARM              = 8'h07;
    localparam byte_t CMD_DISARM           = 8'h08;
    localparam byte_t CMD_SET_ARMED_MODE   = 8'h09;
    localparam byte_t CMD_SOFT_TRIGGER     = 8'h0A;
    localparam byte_t CMD_GET_STATUS       = 8'h0B;
    localparam byte_t CMD_RESET_EDGE_COUNT = 8'h0C;
    localparam byte_t CMD_RESET_COUNT      = 8'h0D;

    localparam int PAYLOAD_BYTES = 4;
    localparam int SYNC_STAGES   = 3;

    // Status reply: count[1:0], delay[5:2], width[9:6], flags[10]
    localparam int STATUS_BYTES = 11;
    localparam int STATUS_IDX_W = $clog2(STATUS_BYTES);
    localparam logic [STATUS_IDX_W-1:0] STATUS_LAST = STATUS_IDX_W'(STATUS_BYTES - 1);

    localparam int FLAG_ARMED        = 0;
    localparam int FLAG_TRIGGER_MODE = 1;
    localparam int FLAG_ARMED_MODE   = 2;
    localparam int FLAG_COUNTER_MODE = 3;
    localparam int FLAG_EDGE_LSB     = 4;  // Edge selection in bits 5:4

    localparam cycles_t DEFAULT_WIDTH       = 32'd1;
    localparam cycles_t DEFAULT_EDGE_TARGET = 32'd1;

    typedef enum logic [1:0] {PS_IDLE, PS_PAYLOAD, PS_APPLY} parser_state_t;

endpackage

// File: source/trigger_edge_sync.sv
module trigger_edge_sync
    import trigger_delay_pkg::*;
(
    input  logic      clk_sys_buf,
    input  logic      rst_sync,
    input  logic      trigger_in,
    input  edge_sel_t edge_sel,
    output logic      edge_pulse
);

    // Synchronizer stages, top bit holds the previous synchronized level
    logic [SYNC_STAGES:0] sync_q;
    logic                 lvl_new;
    logic                 lvl_old;
    logic                 edge_det;

    assign lvl_new = sync_q[SYNC_STAGES-1];
    assign lvl_old = sync_q[SYNC_STAGES];

    always_comb begin
        case (edge_sel)
            EDGE_RISING:  edge_det = lvl_new & ~lvl_old;
            EDGE_FALLING: edge_det = ~lvl_new & lvl_old;
            default:      edge_det = lvl_new ^ lvl_old;  // Both edges, codes 2 and 3
        endcase
    end

    always_ff @(posedge clk_sys_buf) begin
        if (rst_sync) begin
            sync_q     <= '0;
            edge_pulse <= 1'b0;
        end else begin
            sync_q     <= {sync_q[SYNC_STAGES-1:0], trigger_in};
            edge_pulse <= edge_det;
        end
    end

endmodule

// File: source/cmd_parser.sv
module cmd_parser
    import trigger_delay_pkg::*;
(
    input  logic      clk_sys_buf,
    input  logic      rst_sync,
    input  byte_t     rx_data,
    input  logic      rx_valid,
    output cycles_t   delay_cycles,
    output cycles_t   width_cycles,
    output edge_sel_t edge_sel,
    output cycles_t   edge_target,
    output logic      trigger_mode,
    output logic      counter_mode,
    output logic      armed_mode,
    output logic      soft_trigger,
    output logic      arm,
    output logic      disarm,
    output logic      edge_count_clear,
    output logic      count_clear,
    output logic      status_req
);

    parser_state_t                    state;
    byte_t                            cmd_q;
    logic [1:0]                       pay_cnt;     // Bytes left before the final one
    logic [(PAYLOAD_BYTES-1)*8-1:0]   payload_sr;  // Earlier payload bytes, LSB first
    cycles_t                          payload_word;

    // Final byte completes the little-endian word
    assign payload_word = {rx_data, payload_sr};

    always_ff @(posedge clk_sys_buf) begin
        if (state == PS_IDLE && rx_valid) begin
            cmd_q <= rx_data;
        end
        if (state == PS_PAYLOAD && rx_valid) begin
            payload_sr <= {rx_data, payload_sr[$bits(payload_sr)-1:8]};
        end
    end

    // =========================================================================
    // Command FSM and configuration registers
    // =========================================================================
    always_ff @(posedge clk_sys_buf) begin
        if (rst_sync) begin
            state            <= PS_IDLE;
            pay_cnt          <= '0;
            delay_cycles     <= '0;
            width_cycles     <= DEFAULT_WIDTH;
            edge_sel         <= EDGE_RISING;
            edge_target      <= DEFAULT_EDGE_TARGET;
            trigger_mode     <= TRIGGER_MODE_EXTERNAL;
            counter_mode     <= COUNTER_MODE_DISABLED;
            armed_mode       <= ARMED_MODE_SINGLE;
            soft_trigger     <= 1'b0;
            arm              <= 1'b0;
            disarm           <= 1'b0;
            edge_count_clear <= 1'b0;
            count_clear      <= 1'b0;
            status_req       <= 1'b0;
        end else begin
            soft_trigger     <= 1'b0;  // Action pulses last one cycle
            arm              <= 1'b0;
            disarm           <= 1'b0;
            edge_count_clear <= 1'b0;
            count_clear      <= 1'b0;
            status_req       <= 1'b0;

            case (state)
                PS_IDLE: begin
                    if (rx_valid) begin
                        case (rx_data)
                            CMD_SET_DELAY, CMD_SET_WIDTH, CMD_SET_EDGE_TARGET: begin
                                pay_cnt <= 2'(PAYLOAD_BYTES - 2);
                                state   <= PS_PAYLOAD;
                            end
                            CMD_SET_EDGE, CMD_SET_TRIGGER_MODE,
                            CMD_SET_COUNTER_MODE, CMD_SET_ARMED_MODE: state <= PS_APPLY;
                            CMD_ARM:              arm              <= 1'b1;
                            CMD_DISARM:           disarm           <= 1'b1;
                            CMD_SOFT_TRIGGER:     soft_trigger     <= 1'b1;
                            CMD_GET_STATUS:       status_req       <= 1'b1;
                            CMD_RESET_EDGE_COUNT: edge_count_clear <= 1'b1;
                            CMD_RESET_COUNT:      count_clear      <= 1'b1;
                            default: ;  // Unknown codes dropped
                        endcase
                    end
                end

                PS_PAYLOAD: begin
                    if (rx_valid) begin
                        if (pay_cnt == '0) begin
                            state <= PS_APPLY;  // Next byte is the last
                        end else begin
                            pay_cnt <= pay_cnt - 1'b1;
                        end
                    end
                end

                // Last payload byte lands here and updates its register
                PS_APPLY: begin
                    if (rx_valid) begin
                        case (cmd_q)
                            CMD_SET_DELAY:        delay_cycles <= payload_word;
                            CMD_SET_WIDTH:        width_cycles <= payload_word;
                            CMD_SET_EDGE_TARGET:  edge_target  <= payload_word;
                            CMD_SET_EDGE:         edge_sel     <= rx_data[1:0];
                            CMD_SET_TRIGGER_MODE: trigger_mode <= rx_data[0];
                            CMD_SET_COUNTER_MODE: counter_mode <= rx_data[0];
                            CMD_SET_ARMED_MODE:   armed_mode   <= rx_data[0];
                            default: ;
                        endcase
                        state <= PS_IDLE;
                    end
                end

                default: state <= PS_IDLE;
            endcase
        end
    end

    a_one_action: assert property (@(posedge clk_sys_buf) disable iff (rst_sync)
        $onehot0({soft_trigger, arm, disarm, edge_count_clear, count_clear, status_req}));

endmodule

// File: source/trigger_arm_gate.sv
module trigger_arm_gate
    import trigger_delay_pkg::*;
(
    input  logic        clk_sys_buf,
    input  logic        rst_sync,
    input  logic        edge_pulse,
    input  logic        soft_trigger,
    input  logic        trigger_mode,
    input  logic        counter_mode,
    input  cycles_t     edge_target,
    input  logic        armed_mode,
    input  logic        arm,
    input  logic        disarm,
    input  logic        edge_count_clear,
    input  logic        count_clear,
    output logic        fire,
    output logic        armed,
    output trig_count_t trigger_count
);

    cycles_t edge_cnt;
    logic    count_hit;
    logic    nth_edge;
    logic    trig_sel;
    logic    trig_accept;

    // Pin edges only count while armed, so setup time adds nothing
    assign count_hit = edge_pulse && armed && (counter_mode == COUNTER_MODE_ENABLED);
    assign nth_edge  = count_hit && ((edge_cnt + 1'b1) >= edge_target);  // Target 0 or 1 passes all

    always_ff @(posedge clk_sys_buf) begin
        if (rst_sync) begin
            edge_cnt <= '0;
        end else if (edge_count_clear) begin
            edge_cnt <= '0;
        end else if (count_hit) begin
            edge_cnt <= nth_edge ? '0 : edge_cnt + 1'b1;
        end
    end

    // =========================================================================
    // Source select and arm gate
    // =========================================================================
    always_comb begin
        if (trigger_mode == TRIGGER_MODE_INTERNAL) begin
            trig_sel = soft_trigger;
        end else if (counter_mode == COUNTER_MODE_ENABLED) begin
            trig_sel = nth_edge;
        end else begin
            trig_sel = edge_pulse;
        end
    end

    assign trig_accept = trig_sel && armed;

    always_ff @(posedge clk_sys_buf) begin
        if (rst_sync) begin
            fire          <= 1'b0;
            armed         <= 1'b0;
            trigger_count <= '0;
        end else begin
            fire <= trig_accept;

            if (count_clear) begin
                trigger_count <= '0;
            end else if (trig_accept) begin
                trigger_count <= trigger_count + 1'b1;
            end

            if (disarm) begin  // Disarm wins
                armed <= 1'b0;
            end else if (arm) begin
                armed <= 1'b1;
            end else if (trig_accept && armed_mode == ARMED_MODE_SINGLE) begin
                armed <= 1'b0;  // Single shot
            end
        end
    end

    a_fire_armed: assert property (@(posedge clk_sys_buf) disable iff (rst_sync)
        fire |-> $past(armed));

endmodule

// File: source/delay_pulse_gen.sv
module delay_pulse_gen
    import trigger_delay_pkg::*;
(
    input  logic    clk_sys_buf,
    input  logic    rst_sync,
    input  logic    fire,
    input  cycles_t delay_cycles,
    input  cycles_t width_cycles,
    output logic    trigger_out
);

    typedef enum logic [1:0] {PH_IDLE, PH_DELAY, PH_HIGH} phase_t;

    phase_t  phase;
    cycles_t cnt;
    cycles_t width_q;     // Width captured with the trigger
    cycles_t high_len;
    logic    start_high;

    // Pulse starts on a zero-delay fire or when the delay runs out
    assign start_high = (phase == PH_IDLE && fire && delay_cycles == '0) ||
                        (phase == PH_DELAY && cnt == '0);
    assign high_len   = (phase == PH_IDLE) ? width_cycles : width_q;

    always_ff @(posedge clk_sys_buf) begin
        if (phase == PH_IDLE && fire) begin
            width_q <= width_cycles;
        end
    end

    always_ff @(posedge clk_sys_buf) begin
        if (rst_sync) begin
            phase       <= PH_IDLE;
            cnt         <= '0;
            trigger_out <= 1'b0;
        end else if (start_high) begin
            if (high_len == '0) begin
                phase <= PH_IDLE;  // Zero width, no pulse
            end else begin
                phase       <= PH_HIGH;
                trigger_out <= 1'b1;
                cnt         <= high_len - 1'b1;
            end
        end else begin
            case (phase)
                PH_IDLE: begin
                    if (fire) begin
                        phase <= PH_DELAY;
                        cnt   <= delay_cycles - 1'b1;
                    end
                end
                PH_DELAY: cnt <= cnt - 1'b1;
                PH_HIGH: begin
                    if (cnt == '0) begin
                        phase       <= PH_IDLE;
                        trigger_out <= 1'b0;
                    end else begin
                        cnt <= cnt - 1'b1;
                    end
                end
                default: phase <= PH_IDLE;
            endcase
        end
    end

    a_idle_low: assert property (@(posedge clk_sys_buf) disable iff (rst_sync)
        (phase == PH_IDLE) |-> !trigger_out);

endmodule

// File: source/status_tx.sv
module status_tx
    import trigger_delay_pkg::*;
(
    input  logic        clk_sys_buf,
    input  logic        rst_sync,
    input  logic        status_req,
    input  trig_count_t trigger_count,
    input  cycles_t     delay_cycles,
    input  cycles_t     width_cycles,
    input  logic        armed,
    input  logic        trigger_mode,
    input  logic        armed_mode,
    input  logic        counter_mode,
    input  edge_sel_t   edge_sel,
    input  logic        tx_ready,
    output byte_t       tx_data,
    output logic        tx_valid
);

    logic [STATUS_BYTES*8-1:0] snap;  // Byte 0 in the low bits
    logic [STATUS_IDX_W-1:0]   byte_idx;
    byte_t                     flags;

    always_comb begin
        flags                       = '0;
        flags[FLAG_ARMED]           = armed;
        flags[FLAG_TRIGGER_MODE]    = trigger_mode;
        flags[FLAG_ARMED_MODE]      = armed_mode;
        flags[FLAG_COUNTER_MODE]    = counter_mode;
        flags[FLAG_EDGE_LSB +: 2]   = edge_sel;
    end

    // Snapshot only when no reply is running
    always_ff @(posedge clk_sys_buf) begin
        if (status_req && !tx_valid) begin
            snap <= {flags, width_cycles, delay_cycles, trigger_count};
        end
    end

    always_ff @(posedge clk_sys_buf) begin
        if (rst_sync) begin
            tx_valid <= 1'b0;
            byte_idx <= '0;
        end else if (!tx_valid) begin
            if (status_req) begin
                tx_valid <= 1'b1;
                byte_idx <= '0;
            end
        end else if (tx_ready) begin
            if (byte_idx == STATUS_LAST) begin
                tx_valid <= 1'b0;  // Reply done
            end else begin
                byte_idx <= byte_idx + 1'b1;
            end
        end
    end

    assign tx_data = snap[byte_idx*8 +: 8];

    a_tx_hold: assert property (@(posedge clk_sys_buf) disable iff (rst_sync)
        (tx_valid && !tx_ready) |=> (tx_valid && $stable(tx_data)));

endmodule

// File: source/trigger_delay_top.sv
module trigger_delay_top
    import trigger_delay_pkg::*;
(
    input  logic  clk_sys_buf,
    input  logic  rst_sync,
    input  logic  trigger_in,
    input  byte_t rx_data,
    input  logic  rx_valid,
    input  logic  tx_ready,
    output logic  trigger_out,
    output byte_t tx_data,
    output logic  tx_valid
);

    // Configuration levels from the parser
    cycles_t     delay_cycles;
    cycles_t     width_cycles;
    cycles_t     edge_target;
    edge_sel_t   edge_sel;
    logic        trigger_mode;
    logic        counter_mode;
    logic        armed_mode;

    // One-cycle command pulses
    logic        soft_trigger;
    logic        arm;
    logic        disarm;
    logic        edge_count_clear;
    logic        count_clear;
    logic        status_req;

    logic        edge_pulse;
    logic        fire;
    logic        armed;
    trig_count_t trigger_count;

    trigger_edge_sync u_edge_sync (
        .clk_sys_buf (clk_sys_buf),
        .rst_sync    (rst_sync),
        .trigger_in  (trigger_in),
        .edge_sel    (edge_sel),
        .edge_pulse  (edge_pulse)
    );

    cmd_parser u_cmd_parser (
        .clk_sys_buf      (clk_sys_buf),
        .rst_sync         (rst_sync),
        .rx_data          (rx_data),
        .rx_valid         (rx_valid),
        .delay_cycles     (delay_cycles),
        .width_cycles     (width_cycles),
        .edge_sel         (edge_sel),
        .edge_target      (edge_target),
        .trigger_mode     (trigger_mode),
        .counter_mode     (counter_mode),
        .armed_mode       (armed_mode),
        .soft_trigger     (soft_trigger),
        .arm              (arm),
        .disarm           (disarm),
        .edge_count_clear (edge_count_clear),
        .count_clear      (count_clear),
        .status_req       (status_req)
    );

    trigger_arm_gate u_arm_gate (
        .clk_sys_buf      (clk_sys_buf),
        .rst_sync         (rst_sync),
        .edge_pulse       (edge_pulse),
        .soft_trigger     (soft_trigger),
        .trigger_mode     (trigger_mode),
        .counter_mode     (counter_mode),
        .edge_target      (edge_target),
        .armed_mode       (armed_mode),
        .arm              (arm),
        .disarm           (disarm),
        .edge_count_clear (edge_count_clear),
        .count_clear      (count_clear),
        .fire             (fire),
        .armed            (armed),
        .trigger_count    (trigger_count)
    );

    delay_pulse_gen u_pulse_gen (
        .clk_sys_buf  (clk_sys_buf),
        .rst_sync     (rst_sync),
        .fire         (fire),
        .delay_cycles (delay_cycles),
        .width_cycles (width_cycles),
        .trigger_out  (trigger_out)
    );

    status_tx u_status_tx (
        .clk_sys_buf   (clk_sys_buf),
        .rst_sync      (rst_sync),
        .status_req    (status_req),
        .trigger_count (trigger_count),
        .delay_cycles  (delay_cycles),
        .width_cycles  (width_cycles),
        .armed         (armed),
        .trigger_mode  (trigger_mode),
        .armed_mode    (armed_mode),
        .counter_mode  (counter_mode),
        .edge_sel      (edge_sel),
        .tx_ready      (tx_ready),
        .tx_data       (tx_data),
        .tx_valid      (tx_valid)
    );

endmodule

// File: dv/tb_trigger_delay.sv
module tb_trigger_delay
    import trigger_delay_pkg::*;
();

    localparam int CLK_PERIOD    = 10;
    localparam int EDGES         = 10;   // Pin toggles per train
    localparam int MAX_GAP       = 30;
    localparam int QUIET         = 80;   // Longer than pipeline + max delay + max width
    localparam int TRAINS        = 20;
    localparam int COMMANDS      = 60;
    localparam int STATUS_READS  = 6;
    localparam int SOFT_SHOTS    = 8;
    localparam int TIMEOUT_CYCLES = 16 + TRAINS * (EDGES * (MAX_GAP + 1) + QUIET)
                                  + COMMANDS * 12 + STATUS_READS * 200
                                  + SOFT_SHOTS * (MAX_GAP + 4) + QUIET + 1000;

    logic        clk_sys_buf;
    logic        rst_sync;
    logic        trigger_in;
    byte_t       rx_data;
    logic        rx_valid;
    logic        tx_ready;
    logic        trigger_out;
    byte_t       tx_data;
    logic        tx_valid;

    logic [31:0] seed = 32'h11b5;
    logic        checks_on = 1'b0;
    logic        out_prev = 1'b0;
    int          seen_pulses = 0;
    byte_t       reply [STATUS_BYTES];

    // Reference model state
    cycles_t     m_delay, m_width, m_target, m_edge_cnt, m_word, m_plen;
    edge_sel_t   m_edge;
    logic        m_tmode, m_cmode, m_amode, m_armed, m_fire, m_pin_prev, m_exp_out;
    logic        m_soft, m_arm, m_disarm, m_eclr, m_cclr, m_stat;  // Pending command pulses
    logic [3:0]  m_edge_dl;  // Qualified pin edges on their way to the arm gate
    trig_count_t m_count;
    byte_t       m_cmd;
    byte_t       m_snap [STATUS_BYTES];
    int          m_need, m_got, m_pulses;
    longint      m_cyc, m_start, m_busy_end;

    trigger_delay_top UUT (
        .clk_sys_buf (clk_sys_buf),
        .rst_sync    (rst_sync),
        .trigger_in  (trigger_in),
        .rx_data     (rx_data),
        .rx_valid    (rx_valid),
        .tx_ready    (tx_ready),
        .trigger_out (trigger_out),
        .tx_data     (tx_data),
        .tx_valid    (tx_valid)
    );

    initial begin
        clk_sys_buf = 1'b0;
        forever #(CLK_PERIOD / 2) clk_sys_buf = ~clk_sys_buf;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic int unsigned rand_below(input int unsigned n);
        seed = xorshift(seed);
        return seed % n;
    endfunction

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("ERROR %s: expected %h, actual %h at %0t", name, exp, act, $time);
            $display("Checks failed");
            $fatal(1);
        end
    endtask

    // =========================================================================
    // Reference model, one step per clock edge
    // =========================================================================
    always @(posedge clk_sys_buf) begin : model_step
        logic  ep, counted, nth, acc, q;
        byte_t flags;
        if (rst_sync) begin
            m_delay = '0;
            m_width = DEFAULT_WIDTH;
            m_target = DEFAULT_EDGE_TARGET;
            m_edge = EDGE_RISING;
            {m_tmode, m_cmode, m_amode, m_armed, m_fire, m_pin_prev, m_exp_out} = '0;
            {m_soft, m_arm, m_disarm, m_eclr, m_cclr, m_stat} = '0;
            m_edge_dl = '0;
            m_edge_cnt = '0;
            m_count = '0;
            m_need = 0;
            m_pulses = 0;
            m_cyc = 0;
            m_start = 0;
            m_plen = '0;
            m_busy_end = -1;
        end else begin
            m_cyc++;
            // Pulse generator takes a fire only once the previous pulse is over
            if (m_fire && m_cyc > m_busy_end) begin
                m_start = m_cyc + m_delay;
                m_plen = m_width;
                m_busy_end = m_cyc + m_delay + m_width;
                if (m_width != 0) m_pulses++;
            end
            if (m_stat) begin
                flags = '0;
                flags[FLAG_ARMED] = m_armed;
                flags[FLAG_TRIGGER_MODE] = m_tmode;
                flags[FLAG_ARMED_MODE] = m_amode;
                flags[FLAG_COUNTER_MODE] = m_cmode;
                flags[FLAG_EDGE_LSB +: 2] = m_edge;
                for (int i = 0; i < 4; i++) begin
                    m_snap[2 + i] = m_delay[8*i +: 8];
                    m_snap[6 + i] = m_width[8*i +: 8];
                end
                m_snap[0] = m_count[7:0];
                m_snap[1] = m_count[15:8];
                m_snap[10] = flags;
            end
            // Arm gate
            ep = m_edge_dl[3];
            counted = ep && m_armed && m_cmode;
            nth = counted && (m_edge_cnt + 1 >= m_target);
            if (m_eclr) m_edge_cnt = '0;
            else if (counted) m_edge_cnt = nth ? '0 : m_edge_cnt + 1;
            acc = m_armed && (m_tmode ? m_soft : (m_cmode ? nth : ep));
            m_fire = acc;
            if (m_cclr) m_count = '0;
            else if (acc) m_count++;
            if (m_disarm) m_armed = 1'b0;
            else if (m_arm) m_armed = 1'b1;
            else if (acc && m_amode == ARMED_MODE_SINGLE) m_armed = 1'b0;
            // Command stream
            {m_soft, m_arm, m_disarm, m_eclr, m_cclr, m_stat} = '0;
            if (rx_valid && m_need == 0) begin
                m_cmd = rx_data;
                m_got = 0;
                m_word = '0;
                case (rx_data)
                    CMD_SET_DELAY, CMD_SET_WIDTH, CMD_SET_EDGE_TARGET: m_need = PAYLOAD_BYTES;
                    CMD_SET_EDGE, CMD_SET_TRIGGER_MODE,
                    CMD_SET_COUNTER_MODE, CMD_SET_ARMED_MODE: m_need = 1;
                    CMD_ARM:              m_arm = 1'b1;
                    CMD_DISARM:           m_disarm = 1'b1;
                    CMD_SOFT_TRIGGER:     m_soft = 1'b1;
                    CMD_GET_STATUS:       m_stat = 1'b1;
                    CMD_RESET_EDGE_COUNT: m_eclr = 1'b1;
                    CMD_RESET_COUNT:      m_cclr = 1'b1;
                    default: ;
                endcase
            end else if (rx_valid) begin
                m_word[8*m_got +: 8] = rx_data;  // Little-endian payload
                m_got++;
                m_need--;
                if (m_need == 0) begin
                    case (m_cmd)
                        CMD_SET_DELAY:        m_delay = m_word;
                        CMD_SET_WIDTH:        m_width = m_word;
                        CMD_SET_EDGE_TARGET:  m_target = m_word;
                        CMD_SET_EDGE:         m_edge = rx_data[1:0];
                        CMD_SET_TRIGGER_MODE: m_tmode = rx_data[0];
                        CMD_SET_COUNTER_MODE: m_cmode = rx_data[0];
                        CMD_SET_ARMED_MODE:   m_amode = rx_data[0];
                        default: ;
                    endcase
                end
            end
            // Pin edge reaches the gate four edges after it is sampled
            case (m_edge)
                EDGE_RISING:  q = trigger_in & ~m_pin_prev;
                EDGE_FALLING: q = ~trigger_in & m_pin_prev;
                default:      q = trigger_in ^ m_pin_prev;
            endcase
            m_edge_dl = {m_edge_dl[2:0], q};
            m_pin_prev = trigger_in;
            m_exp_out = (m_cyc >= m_start) && (m_cyc < m_start + m_plen);
        end
    end

    always @(negedge clk_sys_buf) begin
        if (checks_on) begin
            check("trigger_out", m_exp_out, trigger_out);
            if (trigger_out && !out_prev) seen_pulses++;
            out_prev = trigger_out;
        end
    end

    // =========================================================================
    // Stimulus tasks
    // =========================================================================
    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk_sys_buf);
    endtask

    task automatic send_byte(input byte_t b);
        @(posedge clk_sys_buf);
        rx_data  <= b;
        rx_valid <= 1'b1;
        @(posedge clk_sys_buf);
        rx_valid <= 1'b0;
    endtask

    task automatic send_word(input byte_t cmd, input cycles_t val);
        send_byte(cmd);
        for (int i = 0; i < PAYLOAD_BYTES; i++) begin
            send_byte(val[8*i +: 8]);
        end
    endtask

    task automatic send_setting(input byte_t cmd, input byte_t val);
        send_byte(cmd);
        send_byte(val);
    endtask

    task automatic random_timing();
        send_word(CMD_SET_DELAY, rand_below(41));
        send_word(CMD_SET_WIDTH, rand_below(13));
    endtask

    // Random toggles, then quiet so settings can change safely
    task automatic pin_train(input int n);
        for (int i = 0; i < n; i++) begin
            wait_cycles(2 + rand_below(MAX_GAP - 1));
            trigger_in <= ~trigger_in;
        end
        wait_cycles(QUIET);
    endtask

    task automatic read_status();
        int idx;
        send_byte(CMD_GET_STATUS);
        idx = 0;
        while (idx < STATUS_BYTES) begin
            @(negedge clk_sys_buf);
            if (tx_valid && tx_ready) begin  // Transfers on the coming edge
                check("tx_data", m_snap[idx], tx_data);
                reply[idx] = tx_data;
                idx++;
            end
            @(posedge clk_sys_buf);
            tx_ready <= (rand_below(4) != 0);
        end
        @(negedge clk_sys_buf);
        check("tx_valid", 1'b0, tx_valid);
    endtask

    initial begin
        #(longint'(TIMEOUT_CYCLES) * CLK_PERIOD);
        $display("Simulation timed out before the tests finished");
        $display("Checks failed");
        $fatal(1);
    end

    initial begin
        rst_sync   = 1'b1;
        trigger_in = 1'b0;
        rx_data    = '0;
        rx_valid   = 1'b0;
        tx_ready   = 1'b0;
        wait_cycles(16);
        rst_sync <= 1'b0;
        checks_on = 1'b1;

        // External rising edge, repeat mode
        send_setting(CMD_SET_ARMED_MODE, ARMED_MODE_REPEAT);
        send_byte(CMD_ARM);
        for (int r = 0; r < 4; r++) begin
            random_timing();
            pin_train(EDGES);
        end
        send_word(CMD_SET_WIDTH, 0);
        pin_train(EDGES);
        read_status();

        // Falling, both, and code 3
        for (int s = 1; s < 4; s++) begin
            send_setting(CMD_SET_EDGE, s);
            random_timing();
            pin_train(EDGES);
        end
        send_setting(CMD_SET_EDGE, EDGE_RISING);
        read_status();

        // Single shot and disarm
        send_setting(CMD_SET_ARMED_MODE, ARMED_MODE_SINGLE);
        send_byte(CMD_ARM);
        pin_train(4);
        read_status();
        check("armed_flag", 1'b0, reply[STATUS_BYTES-1][FLAG_ARMED]);
        send_byte(CMD_ARM);
        pin_train(4);
        send_byte(CMD_ARM);
        send_byte(CMD_DISARM);
        pin_train(4);
        read_status();

        // Every Nth armed edge
        send_setting(CMD_SET_ARMED_MODE, ARMED_MODE_REPEAT);
        send_setting(CMD_SET_COUNTER_MODE, COUNTER_MODE_ENABLED);
        for (int r = 0; r < 3; r++) begin
            send_word(CMD_SET_EDGE_TARGET, 1 + rand_below(4));
            send_byte(CMD_RESET_EDGE_COUNT);
            send_byte(CMD_ARM);
            pin_train(5);
            send_byte(CMD_RESET_EDGE_COUNT);
            pin_train(EDGES);
        end
        send_setting(CMD_SET_COUNTER_MODE, COUNTER_MODE_DISABLED);

        // Soft triggers, pin ignored
        send_setting(CMD_SET_TRIGGER_MODE, TRIGGER_MODE_INTERNAL);
        random_timing();
        pin_train(4);
        for (int i = 0; i < SOFT_SHOTS; i++) begin
            wait_cycles(rand_below(MAX_GAP));
            send_byte(CMD_SOFT_TRIGGER);
        end
        wait_cycles(QUIET);
        send_setting(CMD_SET_TRIGGER_MODE, TRIGGER_MODE_EXTERNAL);
        read_status();

        send_byte(CMD_RESET_COUNT);
        read_status();
        check("status_count", 16'h0, {reply[1], reply[0]});
        wait_cycles(QUIET);
        check("pulse_count", m_pulses, seen_pulses);

        $display("All checks passed");
        $finish;
    end

endmodule

// File: trigger_delay_top.f
source/trigger_delay_pkg.sv
source/trigger_edge_sync.sv
source/cmd_parser.sv
source/trigger_arm_gate.sv
source/delay_pulse_gen.sv
source/status_tx.sv
source/trigger_delay_top.sv
dv/tb_trigger_delay.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the trigger delay testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f trigger_delay_top.f \
    --top-module tb_trigger_delay \
    -o tb_trigger_delay

./obj_dir/tb_trigger_delay 2>&1 | tee "$LOG"

if grep -q "All checks passed" "$LOG"; then
    echo "Simulation PASSED"
else
    echo "Simulation FAILED"
    exit 1
fi
